/* sources.f */
hdl/iso_bridge_pkg.sv
hdl/isochronous_spill_register.sv
hdl/periph_timer.sv
hdl/periph_regfile.sv
hdl/iso_reg_bridge.sv
tb/tb_iso_reg_bridge.sv

/* Makefile */
# Verilator build and run of the isochronous register bridge testbench

TOP = tb_iso_reg_bridge
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"

# The simulation status is ignored so that the log is always shown,
# the search for the pass line decides the result
test:
	rm -f $(LOG)
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_iso_reg_bridge.sv */
// Testbench for the isochronous register bridge
// Table-driven requests in the core domain, in-order response checker with
// random back-pressure, timer poll sequence and a watchdog

`default_nettype none

module tb_iso_reg_bridge
  import iso_bridge_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // One table row holds a request and the response it must produce
  // chk is clear where the data follows the running timer and is not compared
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t exp_data;
    logic  exp_err;
    logic  chk;
  } entry_t;

  // Expected response that is queued once its request has been accepted
  typedef struct packed {
    data_t data;
    logic  err;
    logic  chk;
  } expect_t;

  logic  src_clk_i;
  logic  dst_clk_i;
  logic  rst_n_i;
  logic  req_valid_i;
  logic  req_ready_o;
  logic  req_we_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  logic  rsp_valid_o;
  logic  rsp_ready_i;
  data_t rsp_rdata_o;
  logic  rsp_err_o;

  entry_t      stim_q[$];
  expect_t     exp_q[$];
  logic [31:0] rng_state;
  int          issued_count;
  int          rsp_count;
  data_t       last_rdata;

  // Core clock with a 4 ns period
  always #2 src_clk_i = ~src_clk_i;

  // Peripheral clock at half the core rate with its edges on core rising edges
  always @(posedge src_clk_i) dst_clk_i = ~dst_clk_i;

  iso_reg_bridge #(
    .Bypass (1'b0)
  ) i_iso_reg_bridge (
    .src_clk_i   (src_clk_i),
    .dst_clk_i   (dst_clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic entry_t make_entry(input logic we, input addr_t addr,
                                        input data_t wdata, input data_t exp_data,
                                        input logic exp_err, input logic chk);
    entry_t e;
    e.we       = we;
    e.addr     = addr;
    e.wdata    = wdata;
    e.exp_data = exp_data;
    e.exp_err  = exp_err;
    e.chk      = chk;
    return e;
  endfunction

  function automatic entry_t read_entry(input addr_t addr, input data_t exp_data,
                                        input logic exp_err);
    return make_entry(1'b0, addr, '0, exp_data, exp_err, 1'b1);
  endfunction

  function automatic entry_t write_entry(input addr_t addr, input data_t wdata,
                                         input data_t exp_data, input logic exp_err);
    return make_entry(1'b1, addr, wdata, exp_data, exp_err, 1'b1);
  endfunction

  // Prints the reason, then the verdict, then stops the run
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic check_err(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic build_table();
    data_t r1;
    data_t r2;
    data_t rv;
    r1 = next_random();
    r2 = next_random();
    rv = next_random();
    // ID and COUNT straight after reset while the timer is still off
    stim_q.push_back(read_entry(ADDR_ID, PERIPH_ID, 1'b0));
    stim_q.push_back(read_entry(ADDR_COUNT, '0, 1'b0));
    // SCRATCH and CMP echo the written word and keep it
    stim_q.push_back(write_entry(ADDR_SCRATCH, r1, r1, 1'b0));
    stim_q.push_back(write_entry(ADDR_CMP, r2, r2, 1'b0));
    stim_q.push_back(read_entry(ADDR_SCRATCH, r1, 1'b0));
    stim_q.push_back(read_entry(ADDR_CMP, r2, 1'b0));
    // Read-only registers answer a write with their own contents
    stim_q.push_back(write_entry(ADDR_ID, '1, PERIPH_ID, 1'b0));
    stim_q.push_back(make_entry(1'b1, ADDR_COUNT, rv, '0, 1'b0, 1'b0));
    // CMP of zero keeps the count at zero while CTRL is briefly enabled
    stim_q.push_back(write_entry(ADDR_CMP, '0, '0, 1'b0));
    stim_q.push_back(write_entry(ADDR_CTRL, '1, 32'd1, 1'b0));
    stim_q.push_back(write_entry(ADDR_CTRL, '0, '0, 1'b0));
    stim_q.push_back(read_entry(ADDR_CTRL, '0, 1'b0));
    // Unmapped addresses give zero data with the error flag
    stim_q.push_back(read_entry(3'd6, '0, 1'b1));
    stim_q.push_back(write_entry(3'd6, rv, '0, 1'b1));
    stim_q.push_back(read_entry(3'd7, '0, 1'b1));
    stim_q.push_back(write_entry(3'd7, rv, '0, 1'b1));
    // Back-to-back SCRATCH traffic while the response side stalls at random
    for (int i = 0; i < 16; i++) begin
      rv = next_random();
      stim_q.push_back(write_entry(ADDR_SCRATCH, rv, rv, 1'b0));
      stim_q.push_back(read_entry(ADDR_SCRATCH, rv, 1'b0));
    end
  endtask

  // Holds the request from 0.5 ns after a core edge until the handshake
  // Ready depends only on the pointers, so it is stable between two edges
  task automatic send_request(input entry_t e);
    logic    taken;
    expect_t x;
    taken       = 1'b0;
    req_valid_i = 1'b1;
    req_we_i    = e.we;
    req_addr_i  = e.addr;
    req_wdata_i = e.wdata;
    while (!taken) begin
      taken = req_ready_o;
      if (taken) begin
        x.data = e.exp_data;
        x.err  = e.exp_err;
        x.chk  = e.chk;
        exp_q.push_back(x);
        issued_count++;
      end
      @(posedge src_clk_i);
      #0.5;
    end
    req_valid_i = 1'b0;
  endtask

  // Sends one request and waits until its response has been taken
  task automatic access_and_wait(input entry_t e);
    int target;
    send_request(e);
    target = issued_count;
    do begin
      @(posedge src_clk_i);
    end while (rsp_count < target);
    #0.5;
  endtask

  task automatic drain_responses();
    do begin
      @(posedge src_clk_i);
    end while (exp_q.size() != 0);
    #0.5;
  endtask

  task automatic run_timer_check();
    logic seen;
    int   polls;
    access_and_wait(write_entry(ADDR_CMP, 32'd3, 32'd3, 1'b0));
    // Clears the flag left over from the short enable in the table
    access_and_wait(write_entry(ADDR_STATUS, 32'd1, '0, 1'b0));
    access_and_wait(write_entry(ADDR_CTRL, 32'd1, 32'd1, 1'b0));
    seen  = 1'b0;
    polls = 0;
    while (!seen && polls < 50) begin
      access_and_wait(make_entry(1'b0, ADDR_STATUS, '0, '0, 1'b0, 1'b0));
      seen = last_rdata[0];
      polls++;
    end
    if (!seen) begin
      abort_run("the timer wrap flag in STATUS was still clear after 50 polls");
    end else begin
      // With the timer stopped the clear must stick
      access_and_wait(write_entry(ADDR_CTRL, '0, '0, 1'b0));
      access_and_wait(write_entry(ADDR_STATUS, 32'd1, '0, 1'b0));
      access_and_wait(read_entry(ADDR_STATUS, '0, 1'b0));
    end
  endtask

  // Response checker drives a random ready and compares each response in order
  initial begin
    expect_t x;
    rsp_ready_i = 1'b0;
    @(posedge rst_n_i);
    forever begin
      @(posedge src_clk_i);
      #0.5;
      rng_state   = xorshift32(rng_state);
      rsp_ready_i = rng_state[4];
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          abort_run("a response arrived with no request outstanding");
        end else begin
          x = exp_q.pop_front();
          if (x.chk) begin
            check_data("rsp_rdata_o", x.data, rsp_rdata_o);
          end
          check_err("rsp_err_o", x.err, rsp_err_o);
          last_rdata = rsp_rdata_o;
          rsp_count++;
        end
      end
    end
  end

  // Watchdog sized from the table length plus time for the timer polls
  initial begin
    int limit_ns;
    @(posedge rst_n_i);
    limit_ns = stim_q.size() * 200 + 2000;
    #(limit_ns);
    abort_run("the run timed out before all responses came back");
  end

  initial begin
    src_clk_i    = 1'b0;
    dst_clk_i    = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    rng_state    = 32'h27775652;
    issued_count = 0;
    rsp_count    = 0;
    last_rdata   = '0;
    build_table();
    repeat (5) @(posedge src_clk_i);
    #0.5;
    rst_n_i = 1'b1;
    @(posedge src_clk_i);
    #0.5;
    // Both crossings come out of reset empty
    check_err("req_ready_o", 1'b1, req_ready_o);
    check_err("rsp_valid_o", 1'b0, rsp_valid_o);
    foreach (stim_q[i]) begin
      send_request(stim_q[i]);
    end
    drain_responses();
    run_timer_check();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/iso_reg_bridge.sv */
// Top level of the isochronous register bridge
// Request crossing from the core clock to the peripheral clock,
// register file with its timer, and the response crossing back

`default_nettype none

module iso_reg_bridge
  import iso_bridge_pkg::*;
#(
  // Turns both crossings into wires, legal only with equal clocks
  parameter bit Bypass = 1'b0
) (
  input  logic  src_clk_i,
  input  logic  dst_clk_i,
  input  logic  rst_n_i,
  // Request port, core domain
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  // Response port, core domain
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output logic  rsp_err_o
);

  // Request payload before and after the crossing
  req_t  src_req;
  req_t  dst_req;
  logic  dst_req_valid;
  logic  dst_req_ready;

  // Response payload before and after the crossing
  rsp_t  dst_rsp;
  rsp_t  src_rsp;
  logic  dst_rsp_valid;
  logic  dst_rsp_ready;

  // Timer link inside the peripheral domain
  logic  timer_enable;
  data_t timer_cmp;
  data_t timer_count;
  logic  timer_wrap;

  // Pack the request ports into one payload word
  assign src_req = '{we: req_we_i, addr: req_addr_i, data: req_wdata_i};

  // Request crossing, core clock to peripheral clock
  isochronous_spill_register #(
    .T      (req_t),
    .Bypass (Bypass)
  ) i_req_spill (
    .src_clk_i   (src_clk_i),
    .rst_n_i     (rst_n_i),
    .src_valid_i (req_valid_i),
    .src_ready_o (req_ready_o),
    .src_data_i  (src_req),
    .dst_clk_i   (dst_clk_i),
    .dst_valid_o (dst_req_valid),
    .dst_ready_i (dst_req_ready),
    .dst_data_o  (dst_req)
  );

  // Register file, answers each request in the peripheral domain
  periph_regfile i_regfile (
    .dst_clk_i   (dst_clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (dst_req_valid),
    .req_ready_o (dst_req_ready),
    .req_i       (dst_req),
    .rsp_valid_o (dst_rsp_valid),
    .rsp_ready_i (dst_rsp_ready),
    .rsp_o       (dst_rsp),
    .enable_o    (timer_enable),
    .cmp_o       (timer_cmp),
    .count_i     (timer_count),
    .wrap_i      (timer_wrap)
  );

  // Wrap-around timer steered by the CTRL and CMP registers
  periph_timer i_timer (
    .dst_clk_i (dst_clk_i),
    .rst_n_i   (rst_n_i),
    .enable_i  (timer_enable),
    .cmp_i     (timer_cmp),
    .count_o   (timer_count),
    .wrap_o    (timer_wrap)
  );

  // Response crossing, clocks swapped so the source side runs on the peripheral clock
  isochronous_spill_register #(
    .T      (rsp_t),
    .Bypass (Bypass)
  ) i_rsp_spill (
    .src_clk_i   (dst_clk_i),
    .rst_n_i     (rst_n_i),
    .src_valid_i (dst_rsp_valid),
    .src_ready_o (dst_rsp_ready),
    .src_data_i  (dst_rsp),
    .dst_clk_i   (src_clk_i),
    .dst_valid_o (rsp_valid_o),
    .dst_ready_i (rsp_ready_i),
    .dst_data_o  (src_rsp)
  );

  // Unpack the response payload onto the core-side ports
  assign rsp_rdata_o = src_rsp.data;
  assign rsp_err_o   = src_rsp.err;

endmodule

`default_nettype wire

/* hdl/periph_regfile.sv */
// Register file of the peripheral domain
// Decodes each request, holds the SCRATCH, CTRL, CMP and STATUS registers,
// answers every request with exactly one response and steers the timer

`default_nettype none

module periph_regfile
  import iso_bridge_pkg::*;
(
  input  logic  dst_clk_i,
  input  logic  rst_n_i,
  // Request side, fed by the request crossing
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  req_t  req_i,
  // Response side, feeding the response crossing
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output rsp_t  rsp_o,
  // Timer control and status
  output logic  enable_o,
  output data_t cmp_o,
  input  data_t count_i,
  input  logic  wrap_i
);

  // Register state
  data_t scratch_q;
  logic  enable_q;
  data_t cmp_q;
  logic  status_q;

  // Register values with the current request already applied
  data_t scratch_w;
  logic  enable_w;
  data_t cmp_w;
  logic  status_w;

  // Response fields
  data_t rsp_data;
  logic  rsp_err;

  // Request and response share one handshake
  logic  fire;

  // The file answers in the same cycle, so the request is taken
  // exactly when the response crossing can take the answer
  assign rsp_valid_o = req_valid_i;
  assign req_ready_o = rsp_ready_i;
  assign fire        = req_valid_i && rsp_ready_i;

  // Address decode and response generation
  // A write answers with the register contents as they stand after the write
  always_comb begin
    scratch_w = scratch_q;
    enable_w  = enable_q;
    cmp_w     = cmp_q;
    // A wrap sets the sticky flag in every cycle
    status_w  = status_q || wrap_i;
    rsp_data  = '0;
    rsp_err   = 1'b0;

    case (req_i.addr)
      ADDR_ID: begin
        rsp_data = PERIPH_ID;
      end
      ADDR_SCRATCH: begin
        if (req_i.we) begin
          scratch_w = req_i.data;
        end
        rsp_data = scratch_w;
      end
      ADDR_CTRL: begin
        // Only the enable bit is kept, the upper bits read back as zero
        if (req_i.we) begin
          enable_w = req_i.data[0];
        end
        rsp_data = data_t'(enable_w);
      end
      ADDR_CMP: begin
        if (req_i.we) begin
          cmp_w = req_i.data;
        end
        rsp_data = cmp_w;
      end
      ADDR_COUNT: begin
        // Read-only, a write just returns the running count
        rsp_data = count_i;
      end
      ADDR_STATUS: begin
        // Writing 1 clears the flag, but a wrap in the same cycle keeps it set
        if (req_i.we && req_i.data[0]) begin
          status_w = wrap_i;
        end
        rsp_data = data_t'(status_w);
      end
      default: begin
        // Unmapped, zero data with the error flag and no side effect
        rsp_err = 1'b1;
      end
    endcase
  end

  assign rsp_o = '{data: rsp_data, err: rsp_err};

  // Control registers, written on the handshake edge only
  always_ff @(posedge dst_clk_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
      status_q <= 1'b0;
    end else if (fire) begin
      enable_q <= enable_w;
      cmp_q    <= cmp_w;
      status_q <= status_w;
    end else begin
      status_q <= status_q || wrap_i;
    end
  end

  // Scratch word carries data only
  always_ff @(posedge dst_clk_i) begin
    if (fire) begin
      scratch_q <= scratch_w;
    end
  end

  assign enable_o = enable_q;
  assign cmp_o    = cmp_q;

endmodule

`default_nettype wire

/* hdl/periph_timer.sv */
// Wrap-around timer of the peripheral domain
// Counts while enabled, returns to zero after reaching the compare value
// and raises a one-cycle wrap pulse

`default_nettype none

module periph_timer
  import iso_bridge_pkg::*;
(
  input  logic  dst_clk_i,
  input  logic  rst_n_i,
  input  logic  enable_i,
  input  data_t cmp_i,
  output data_t count_o,
  output logic  wrap_o
);

  data_t count_q;
  logic  wrap_q;
  logic  at_cmp;

  // The count has reached its top value for this period
  assign at_cmp = (count_q == cmp_i);

  // Counter register, holds its value while the timer is disabled
  always_ff @(posedge dst_clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (enable_i) begin
      if (at_cmp) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + data_t'(1);
      end
    end
  end

  // Wrap pulse, high for the single cycle after the count returned to zero
  always_ff @(posedge dst_clk_i) begin
    if (!rst_n_i) begin
      wrap_q <= 1'b0;
    end else begin
      wrap_q <= enable_i && at_cmp;
    end
  end

  assign count_o = count_q;
  assign wrap_o  = wrap_q;

endmodule

`default_nettype wire

/* hdl/isochronous_spill_register.sv */
// Two-entry dual-clock spill register for isochronous clock domains
// Write pointer lives in the source domain, read pointer in the destination domain
// Optional bypass turns the block into plain wires

`default_nettype none

module isochronous_spill_register #(
  // Payload type carried across the crossing
  parameter type T      = logic,
  // Set to 1 only when both clocks are the same
  parameter bit  Bypass = 1'b0
) (
  // Source side
  input  logic src_clk_i,
  input  logic rst_n_i,
  input  logic src_valid_i,
  output logic src_ready_o,
  input  T     src_data_i,
  // Destination side
  input  logic dst_clk_i,
  output logic dst_valid_o,
  input  logic dst_ready_i,
  output T     dst_data_o
);

  if (Bypass) begin : gen_bypass
    // Straight connection, the handshake passes through unchanged
    assign dst_valid_o = src_valid_i;
    assign src_ready_o = dst_ready_i;
    assign dst_data_o  = src_data_i;
  end else begin : gen_spill
    // Both pointers carry one bit more than the two entries need
    // The low bit addresses the memory, the high bit tells a full FIFO from an empty one
    logic [1:0] wr_ptr_q;
    logic [1:0] rd_ptr_q;
    logic [1:0] ptr_diff;
    logic       push;
    logic       pop;

    // Two storage entries, written only from the source domain
    T mem_q [2];

    assign push = src_valid_i && src_ready_o;
    assign pop  = dst_valid_o && dst_ready_i;

    // Static timing covers the paths between the domains, so the pointers
    // are compared directly without any synchronizer stages
    assign ptr_diff = wr_ptr_q ^ rd_ptr_q;

    // Full when the low bits agree and the high bits differ
    assign src_ready_o = (ptr_diff != 2'b10);

    // Anything but an exact match means at least one entry is held
    assign dst_valid_o = (ptr_diff != 2'b00);

    assign dst_data_o = mem_q[rd_ptr_q[0]];

    // Write pointer advances on each accepted source transfer
    always_ff @(posedge src_clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= 2'b00;
      end else if (push) begin
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
    end

    // Payload storage, the entry under the write pointer takes the new data
    always_ff @(posedge src_clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q[0]] <= src_data_i;
      end
    end

    // Read pointer advances once the destination has taken the head entry
    always_ff @(posedge dst_clk_i) begin
      if (!rst_n_i) begin
        rd_ptr_q <= 2'b00;
      end else if (pop) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/iso_bridge_pkg.sv */
// Shared definitions for the isochronous register bridge
// Address and data widths, the peripheral register map,
// and the request and response payloads of the two crossings

`default_nettype none

package iso_bridge_pkg;

  // Register address, enough for eight registers
  typedef logic [2:0] addr_t;

  // Register data word
  typedef logic [31:0] data_t;

  // Request payload from the core domain to the peripheral domain
  // The write flag selects between a read and a write of addr
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t data;
  } req_t;

  // Response payload from the peripheral domain back to the core domain
  // A set err flag marks an access to an unmapped address
  typedef struct packed {
    data_t data;
    logic  err;
  } rsp_t;

  // Peripheral register map
  // Addresses 6 and 7 are left unmapped and answer with an error
  localparam addr_t ADDR_ID      = 3'd0;
  localparam addr_t ADDR_SCRATCH = 3'd1;
  localparam addr_t ADDR_CTRL    = 3'd2;
  localparam addr_t ADDR_CMP     = 3'd3;
  localparam addr_t ADDR_COUNT   = 3'd4;
  localparam addr_t ADDR_STATUS  = 3'd5;

  // Fixed identification word returned by the ID register
  localparam data_t PERIPH_ID = 32'h1C0B_0001;

endpackage

`default_nettype wire
